// File: Bender.yml
package:
  name: vector_rotate

export_include_dirs:
  - include

sources:
  - files:
      - source/vecrot_pkg.sv
      - source/quat_mult_if.sv
      - source/pipe_delay.sv
      - source/fp16_mul.sv
      - source/fp16_add_sub.sv
      - source/quaternion_mult.sv
      - source/vector_rotate.sv
  - target: test
    files:
      - dv/vector_rotate_assert.sv
      - dv/vector_rotate_tb.sv

// File: dv/vector_rotate_assert.sv
`include "vecrot_params.svh"

module vector_rotate_assert (
    input logic            clk,
    input logic            arst_n,
    input logic            valid_in,
    input logic            valid_out,
    input vecrot_pkg::vec3 vec_out
);

    timeunit 1ns;
    timeprecision 1ps;

    // outputs cleared by the reset
    a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !valid_out)
        else $error("valid_out high during reset");

    // fixed pipeline depth, no stalls
    a_fixed_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        valid_out == $past(valid_in, `VECROT_ROT_LATENCY)
    ) else $error("valid_out does not follow valid_in by the rotation latency");

    a_known_result: assert property (
        @(posedge clk) disable iff (!arst_n)
        valid_out |-> !$isunknown(vec_out)
    ) else $error("vec_out has unknown bits while valid_out is high");

endmodule

// File: dv/vector_rotate_golden.txt
// columns: rot real i j k, vec_in x y z, expected vec_out x y z
// fp16 hex, truncating arithmetic in the rotator's operation order
// identity
3C00 0000 0000 0000 3C00 4000 4200 3C00 4000 4200
3C00 0000 0000 0000 BC00 3800 4780 BC00 3800 4780
3C00 0000 0000 0000 2E66 B555 63D0 2E66 B555 63D0
3C00 0000 0000 0000 5640 C000 3400 5640 C000 3400
// 180 degrees about z
0000 0000 0000 3C00 3C00 4000 4200 BC00 C000 4200
0000 0000 0000 3C00 BC00 3800 4780 3C00 B800 4780
0000 0000 0000 3C00 2E66 B555 63D0 AE66 3555 63D0
0000 0000 0000 3C00 5640 C000 3400 D640 4000 3400
// 90 degrees about z, x, y
39A8 0000 0000 39A8 3C00 0000 0000 0000 3BFF 0000
39A8 0000 0000 39A8 0000 0000 3C00 0000 0000 3BFF
39A8 39A8 0000 0000 0000 3C00 0000 0000 0000 3BFF
39A8 0000 39A8 0000 0000 0000 3C00 3BFF 0000 0000
// 120 degrees about (1, 1, 1)
3800 3800 3800 3800 3C00 4000 4400 4400 3C00 4000
3800 3800 3800 3800 4000 C200 3800 3800 4000 C200
3800 3800 3800 3800 BC00 3E00 4500 4500 BC00 3E00

// File: dv/vector_rotate_tb.sv
`include "vecrot_params.svh"

module vector_rotate_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD     = 10;
    localparam int    RST_CYCLES     = 16;
    localparam int    MAX_CASES      = 64;
    localparam int    WORDS_PER_CASE = 10;  // 4 rot, 3 vec in, 3 expected
    localparam int    MAX_GAP        = 3;   // two lfsr bits per gap
    localparam int    DRAIN_MARGIN   = 50;
    localparam string GOLDEN_FILE    = "dv/vector_rotate_golden.txt";

    logic                  clk;
    logic                  arst_n;
    logic                  valid_in;
    vecrot_pkg::vec3       vec_in;
    vecrot_pkg::quaternion rot;
    logic                  valid_out;
    vecrot_pkg::vec3       vec_out;

    logic [15:0]     golden_mem [MAX_CASES*WORDS_PER_CASE];  // all cases back to back
    int              n_cases;
    bit              cases_loaded;
    logic [31:0]     lfsr_state;
    vecrot_pkg::vec3 exp_q  [$];  // expected results in arrival order
    int              cyc_q  [$];  // cycle each item went in
    string           name_q [$];
    int              cycle;

    vector_rotate vector_rotate_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (valid_in),
        .vec_in    (vec_in),
        .rot       (rot),
        .valid_out (valid_out),
        .vec_out   (vec_out)
    );

    bind vector_rotate vector_rotate_assert assert_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (valid_in),
        .valid_out (valid_out),
        .vec_out   (vec_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle++;  // read on the falling edge only

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_random_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);
        b          = lfsr_state[0];
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped on first error");
    endtask

    task automatic drive_case(input int idx, input string pass_name);
        vecrot_pkg::vec3 exp_vec;
        int              base;
        base = idx * WORDS_PER_CASE;
        @(negedge clk);
        valid_in = 1'b1;
        for (int n = 0; n < 4; n++) begin
            rot[n] = golden_mem[base + n];  // real, i, j, k
        end
        for (int n = 0; n < 3; n++) begin
            vec_in[n]  = golden_mem[base + 4 + n];  // x, y, z
            exp_vec[n] = golden_mem[base + 7 + n];
        end
        exp_q.push_back(exp_vec);
        cyc_q.push_back(cycle);
        name_q.push_back($sformatf("%s_case%0d", pass_name, idx));
    endtask

    task automatic drive_idle();
        @(negedge clk);
        valid_in = 1'b0;  // data left as is
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // output side sampled away from the rising edge
    always @(negedge clk) begin
        vecrot_pkg::vec3 exp_vec;
        int              in_cyc;
        string           name;
        if (!arst_n) begin
            assert (valid_out !== 1'b1)
            else report_failure("valid_out went high while reset was asserted");
        end else if (valid_out === 1'b1) begin
            assert (exp_q.size() != 0)
            else report_failure("valid_out pulsed with no input in flight");
            exp_vec = exp_q.pop_front();
            in_cyc  = cyc_q.pop_front();
            name    = name_q.pop_front();
            assert (cycle - in_cyc == `VECROT_ROT_LATENCY)
            else report_failure($sformatf("[ERROR] %s latency expected %0d actual %0d",
                                          name, `VECROT_ROT_LATENCY, cycle - in_cyc));
            assert (vec_out === exp_vec)
            else report_failure($sformatf(
                "[ERROR] %s vec_out expected x=%h y=%h z=%h actual x=%h y=%h z=%h",
                name, exp_vec[0], exp_vec[1], exp_vec[2],
                vec_out[0], vec_out[1], vec_out[2]));
        end
    end

    // stops a run whose results never show up
    initial begin
        int limit;
        wait (cases_loaded);
        limit = RST_CYCLES + n_cases * (2 + MAX_GAP) + `VECROT_ROT_LATENCY + DRAIN_MARGIN;
        repeat (limit) @(posedge clk);
        report_failure("timeout, the rotated vectors never arrived");
    end

    initial begin
        logic g0;
        logic g1;
        int   gap;
        clk        = 1'b0;
        arst_n     = 1'b0;
        valid_in   = 1'b0;
        vec_in     = '0;
        rot        = '0;
        lfsr_state = 32'h4824_f51c;
        cycle      = 0;

        $readmemh(GOLDEN_FILE, golden_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && !$isunknown(golden_mem[n_cases * WORDS_PER_CASE])) begin
            n_cases++;  // unwritten entries stay x
        end
        assert (n_cases > 0)
        else report_failure("golden file missing or holds no cases");
        cases_loaded = 1'b1;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // one case per cycle
        for (int i = 0; i < n_cases; i++) begin
            drive_case(i, "burst");
        end
        drive_idle();
        wait_drain();

        // random idle cycles in front of each case
        for (int i = 0; i < n_cases; i++) begin
            next_random_bit(g0);
            next_random_bit(g1);
            gap = {g1, g0};
            repeat (gap) drive_idle();
            drive_case(i, "gapped");
        end
        drive_idle();
        wait_drain();

        repeat (`VECROT_ROT_LATENCY + 4) @(negedge clk);  // catch stray pulses
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
source/vecrot_pkg.sv
source/quat_mult_if.sv
source/pipe_delay.sv
source/fp16_mul.sv
source/fp16_add_sub.sv
source/quaternion_mult.sv
source/vector_rotate.sv
dv/vector_rotate_assert.sv
dv/vector_rotate_tb.sv

// File: include/vecrot_params.svh
`ifndef VECROT_PARAMS_SVH
`define VECROT_PARAMS_SVH

// half-precision word
`define VECROT_FP_W 16

// float unit depths, valid in to valid out
`define VECROT_MUL_STAGES 2
`define VECROT_ADD_STAGES 3

// one hamilton product: multiply, pair level, combine level
`define VECROT_QMUL_LATENCY (`VECROT_MUL_STAGES + 2 * `VECROT_ADD_STAGES)

// q*v then (q*v)*conj(q)
`define VECROT_ROT_LATENCY (2 * `VECROT_QMUL_LATENCY)

// the sink must accept one result per cycle, no stall path

`endif

// File: source/fp16_add_sub.sv
`include "vecrot_params.svh"

module fp16_add_sub (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               valid_in,
    input  vecrot_pkg::fp_op_e op,
    input  vecrot_pkg::float16 a,
    input  vecrot_pkg::float16 b,
    output logic               valid_out,
    output vecrot_pkg::float16 s
);

    localparam logic signed [6:0] NORM_POS = 7'sd10;  // hidden bit position

    vecrot_pkg::float16     b_eff;       // b after op applied
    vecrot_pkg::float16     op_big;      // larger magnitude
    vecrot_pkg::float16     op_small;
    logic                   a_big;
    logic [10:0]            mant_big;
    logic [10:0]            mant_small;
    logic [10:0]            mant_shift;  // small, aligned to big
    logic [4:0]             exp_diff;
    logic                   same_sign;
    logic [11:0]            mag;         // extra bit for carry out
    logic [3:0]             lead;        // position of leading one
    logic [11:0]            mag_norm;
    logic signed [6:0]      exp_res;
    vecrot_pkg::float16     s_comb;
    vecrot_pkg::fp_result_t res_d;
    vecrot_pkg::fp_result_t res_q;

    assign b_eff = '{
        sign: b.sign ^ (op == vecrot_pkg::fp_sub),  // a - b as a + (-b)
        exp:  b.exp,
        frac: b.frac
    };

    // compare magnitudes, exponent field dominates
    assign a_big    = {a.exp, a.frac} >= {b_eff.exp, b_eff.frac};
    assign op_big   = a_big ? a : b_eff;
    assign op_small = a_big ? b_eff : a;

    // subnormals count as zero
    assign mant_big   = (op_big.exp == 5'd0) ? 11'd0 : {1'b1, op_big.frac};
    assign mant_small = (op_small.exp == 5'd0) ? 11'd0 : {1'b1, op_small.frac};

    assign exp_diff   = op_big.exp - op_small.exp;  // never negative
    assign mant_shift = mant_small >> exp_diff;     // shifted-out bits dropped
    assign same_sign  = op_big.sign == op_small.sign;

    assign mag = same_sign ? {1'b0, mant_big} + {1'b0, mant_shift}
                           : {1'b0, mant_big} - {1'b0, mant_shift};

    // leading-one search, highest set bit wins
    always_comb begin
        lead = 4'd0;
        for (int i = 0; i < 12; i++) begin
            if (mag[i]) begin
                lead = i[3:0];
            end
        end
    end

    assign mag_norm = mag << (4'd11 - lead);  // leading one to bit 11
    assign exp_res  = $signed({2'b00, op_big.exp}) + $signed({3'b000, lead}) - NORM_POS;

    always_comb begin
        s_comb = '{sign: 1'b0, exp: 5'd0, frac: 10'd0};  // exact cancel gives +0
        if (mag != 12'd0) begin
            s_comb.sign = op_big.sign;
            if (exp_res >= 7'sd31) begin
                s_comb.exp = 5'h1f;  // overflow to inf
            end else if (exp_res > 7'sd0) begin
                s_comb.exp  = exp_res[4:0];
                s_comb.frac = mag_norm[10:1];  // truncate
            end  // underflow flushes to signed zero
        end
    end

    assign res_d = '{valid: valid_in, value: s_comb};

    pipe_delay #(
        .T     (vecrot_pkg::fp_result_t),
        .DEPTH (`VECROT_ADD_STAGES)
    ) res_dly_i (
        .clk    (clk),
        .arst_n (arst_n),
        .d      (res_d),
        .q      (res_q)
    );

    assign valid_out = res_q.valid;
    assign s         = res_q.value;

endmodule

// File: source/fp16_mul.sv
`include "vecrot_params.svh"

module fp16_mul (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               valid_in,
    input  vecrot_pkg::float16 a,
    input  vecrot_pkg::float16 b,
    output logic               valid_out,
    output vecrot_pkg::float16 p
);

    localparam logic signed [6:0] BIAS = 7'sd15;

    logic [10:0]            mant_a;     // hidden one restored
    logic [10:0]            mant_b;
    logic [21:0]            mant_prod;  // 1.x * 1.x, in [1, 4)
    logic signed [6:0]      exp_sum;    // unbiased sum, rebiased once
    logic signed [6:0]      exp_norm;
    logic [9:0]             frac_norm;
    logic                   res_sign;
    vecrot_pkg::float16     p_comb;
    vecrot_pkg::fp_result_t res_d;
    vecrot_pkg::fp_result_t res_q;

    assign res_sign  = a.sign ^ b.sign;
    assign mant_a    = {1'b1, a.frac};
    assign mant_b    = {1'b1, b.frac};
    assign mant_prod = mant_a * mant_b;
    assign exp_sum   = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp}) - BIAS;

    always_comb begin
        if (mant_prod[21]) begin  // product >= 2, shift right one
            exp_norm  = exp_sum + 7'sd1;
            frac_norm = mant_prod[20:11];  // truncate, round toward zero
        end else begin
            exp_norm  = exp_sum;
            frac_norm = mant_prod[19:10];
        end
    end

    always_comb begin
        p_comb = '{sign: res_sign, exp: 5'd0, frac: 10'd0};  // signed zero by default
        if (a.exp != 5'd0 && b.exp != 5'd0) begin  // zero/subnormal in -> zero out
            if (exp_norm >= 7'sd31) begin
                p_comb.exp = 5'h1f;  // saturate to inf
            end else if (exp_norm > 7'sd0) begin
                p_comb.exp  = exp_norm[4:0];
                p_comb.frac = frac_norm;
            end  // else underflow, stays flushed
        end
    end

    assign res_d = '{valid: valid_in, value: p_comb};

    pipe_delay #(
        .T     (vecrot_pkg::fp_result_t),
        .DEPTH (`VECROT_MUL_STAGES)
    ) res_dly_i (
        .clk    (clk),
        .arst_n (arst_n),
        .d      (res_d),
        .q      (res_q)
    );

    assign valid_out = res_q.valid;
    assign p         = res_q.value;

endmodule

// File: source/pipe_delay.sv
module pipe_delay #(
    parameter type T     = logic,  // payload
    parameter int  DEPTH = 1       // register stages, at least one
) (
    input  logic clk,
    input  logic arst_n,
    input  T     d,
    output T     q
);

    T stage_q [DEPTH];  // stage 0 nearest the input

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;  // valid bits come out low
            end
        end else begin
            stage_q[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];  // shift one place per clock
            end
        end
    end

    assign q = stage_q[DEPTH-1];

endmodule

// File: source/quat_mult_if.sv
interface quat_mult_if;

    logic                  valid_in;   // one-cycle strobe per operand pair
    vecrot_pkg::quaternion a;          // left factor
    vecrot_pkg::quaternion b;          // right factor
    logic                  valid_out;  // strobe, fixed latency after valid_in
    vecrot_pkg::quaternion c;          // a * b

    // side that feeds operands and takes the product
    modport client (
        output valid_in, a, b,
        input  valid_out, c
    );

    // the multiplier itself
    modport server (
        input  valid_in, a, b,
        output valid_out, c
    );

endinterface

// File: source/quaternion_mult.sv
module quaternion_mult (
    input  logic        clk,
    input  logic        arst_n,
    quat_mult_if.server qm
);

    // bit p set -> subtract for output part p (r, i, j, k)
    localparam logic [3:0] L1_LO_SUB = 4'b0101;  // r: p0-p1, j: p0-p1
    localparam logic [3:0] L1_HI_SUB = 4'b1010;  // i: p2-p3, k: p2-p3
    localparam logic [3:0] L2_SUB    = 4'b1001;  // r and k subtract pairs

    vecrot_pkg::quaternion b_perm [4];     // b reordered per output part
    vecrot_pkg::float16    prod   [4][4];  // a[n] * b_perm[p][n]
    logic                  mul_v  [4][4];
    vecrot_pkg::float16    l1_s   [4][2];  // pair sums/differences
    logic                  l1_v   [4][2];
    vecrot_pkg::float16    l2_s   [4];     // final parts
    logic                  l2_v   [4];

    assign b_perm[0] = qm.b;                                   // r: b0 b1 b2 b3
    assign b_perm[1] = {qm.b[2], qm.b[3], qm.b[0], qm.b[1]};   // i: b1 b0 b3 b2
    assign b_perm[2] = {qm.b[1], qm.b[0], qm.b[3], qm.b[2]};   // j: b2 b3 b0 b1
    assign b_perm[3] = {qm.b[0], qm.b[1], qm.b[2], qm.b[3]};   // k: b3 b2 b1 b0

    for (genvar p = 0; p < 4; p++) begin : g_part
        for (genvar n = 0; n < 4; n++) begin : g_mul
            fp16_mul mul_i (
                .clk       (clk),
                .arst_n    (arst_n),
                .valid_in  (qm.valid_in),
                .a         (qm.a[n]),
                .b         (b_perm[p][n]),
                .valid_out (mul_v[p][n]),
                .p         (prod[p][n])
            );
        end

        fp16_add_sub add_lo_i (
            .clk       (clk),
            .arst_n    (arst_n),
            .valid_in  (mul_v[p][0] & mul_v[p][1]),
            .op        (vecrot_pkg::fp_op_e'(L1_LO_SUB[p])),
            .a         (prod[p][0]),
            .b         (prod[p][1]),
            .valid_out (l1_v[p][0]),
            .s         (l1_s[p][0])
        );

        fp16_add_sub add_hi_i (
            .clk       (clk),
            .arst_n    (arst_n),
            .valid_in  (mul_v[p][2] & mul_v[p][3]),
            .op        (vecrot_pkg::fp_op_e'(L1_HI_SUB[p])),
            .a         (prod[p][2]),
            .b         (prod[p][3]),
            .valid_out (l1_v[p][1]),
            .s         (l1_s[p][1])
        );

        fp16_add_sub add_comb_i (
            .clk       (clk),
            .arst_n    (arst_n),
            .valid_in  (l1_v[p][0] & l1_v[p][1]),
            .op        (vecrot_pkg::fp_op_e'(L2_SUB[p])),
            .a         (l1_s[p][0]),
            .b         (l1_s[p][1]),
            .valid_out (l2_v[p]),
            .s         (l2_s[p])
        );
    end

    assign qm.c         = {l2_s[3], l2_s[2], l2_s[1], l2_s[0]};
    assign qm.valid_out = l2_v[0];  // real chain, all chains equal depth

endmodule

// File: source/vecrot_pkg.sv
package vecrot_pkg;

    // ieee 754 binary16
    typedef struct packed {
        logic       sign;   // 1 = negative
        logic [4:0] exp;    // biased by 15
        logic [9:0] frac;   // hidden one not stored
    } float16;

    // x in [0], y in [1], z in [2]
    typedef float16 [2:0] vec3;

    // real in [0], then i, j, k
    typedef float16 [3:0] quaternion;

    // adder operation select
    typedef enum logic {
        fp_add = 1'b0,
        fp_sub = 1'b1   // flips sign of b
    } fp_op_e;

    // what travels down a float unit's delay line
    typedef struct packed {
        logic   valid;
        float16 value;
    } fp_result_t;

endpackage

// File: source/vector_rotate.sv
`include "vecrot_params.svh"

module vector_rotate (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  valid_in,
    input  vecrot_pkg::vec3       vec_in,
    input  vecrot_pkg::quaternion rot,    // unit quaternion assumed
    output logic                  valid_out,
    output vecrot_pkg::vec3       vec_out
);

    quat_mult_if fwd_if ();   // rot * v
    quat_mult_if back_if ();  // (rot * v) * conj(rot)

    vecrot_pkg::quaternion q_vec;       // pure quaternion from vec_in
    vecrot_pkg::quaternion rot_conj;
    vecrot_pkg::quaternion rot_conj_d;  // lines up with fwd_if.c

    assign q_vec = {vec_in, `VECROT_FP_W'(0)};  // real part zero, x y z in i j k

    always_comb begin
        rot_conj = rot;
        for (int n = 1; n < 4; n++) begin
            rot_conj[n].sign = ~rot[n].sign;  // negate i, j, k
        end
    end

    // conjugate waits out the first product
    pipe_delay #(
        .T     (vecrot_pkg::quaternion),
        .DEPTH (`VECROT_QMUL_LATENCY)
    ) conj_dly_i (
        .clk    (clk),
        .arst_n (arst_n),
        .d      (rot_conj),
        .q      (rot_conj_d)
    );

    assign fwd_if.valid_in = valid_in;
    assign fwd_if.a        = rot;
    assign fwd_if.b        = q_vec;

    quaternion_mult fwd_mult_i (
        .clk    (clk),
        .arst_n (arst_n),
        .qm     (fwd_if)
    );

    assign back_if.valid_in = fwd_if.valid_out;
    assign back_if.a        = fwd_if.c;
    assign back_if.b        = rot_conj_d;

    quaternion_mult back_mult_i (
        .clk    (clk),
        .arst_n (arst_n),
        .qm     (back_if)
    );

    assign valid_out = back_if.valid_out;
    assign vec_out   = back_if.c[3:1];  // drop real part

endmodule
